//--- design/tomasulo_pkg.sv
`default_nettype none

package tomasulo_pkg;

    localparam int XLEN           = 32;
    localparam int NUM_REGS       = 32;
    localparam int REG_W          = 5;
    localparam int ROB_DEPTH      = 8;
    localparam int TAG_W          = 3;
    localparam int CNT_W          = TAG_W + 1;
    localparam int NUM_RS         = 4;
    localparam int RS_SEL_W       = $clog2(NUM_RS);
    localparam int RS_DEPTH       = 2;
    localparam int IQ_DEPTH       = 4;
    localparam int COMMIT_CREDITS = 4;
    localparam int CRED_W         = $clog2(COMMIT_CREDITS + 1);

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    // data is the value when valid, otherwise tag names the producer
    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  data;
    } operand_t;

    typedef struct packed {
        alu_op_e          op;
        operand_t         src1;
        operand_t         src2;
        logic [TAG_W-1:0] dest_tag;
    } rs_word_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  data;
    } cdb_t;

    typedef struct packed {
        logic [REG_W-1:0] rd;
        logic [XLEN-1:0]  data;
    } commit_t;

    // waiting operand picks up a matching broadcast
    function automatic operand_t snoop(operand_t op, cdb_t cdb);
        operand_t res;
        res = op;
        if (!op.valid && cdb.valid && cdb.tag == op.tag) begin
            res.valid = 1'b1;
            res.data  = cdb.data;
        end
        return res;
    endfunction

endpackage

`default_nettype wire

//--- design/rv32i_alu.sv
`timescale 1ns/10ps
`default_nettype none

module rv32i_alu (
    input  tomasulo_pkg::alu_op_e         op_i,
    input  logic [tomasulo_pkg::XLEN-1:0] a_i,
    input  logic [tomasulo_pkg::XLEN-1:0] b_i,
    output logic [tomasulo_pkg::XLEN-1:0] result_o
);

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        result_o = '0;
        case (op_i)
            tomasulo_pkg::ALU_ADD:  result_o = a_i + b_i;
            tomasulo_pkg::ALU_SUB:  result_o = a_i - b_i;
            tomasulo_pkg::ALU_SLL:  result_o = a_i << shamt;
            // compares only set bit 0
            tomasulo_pkg::ALU_SLT:  result_o[0] = $signed(a_i) < $signed(b_i);
            tomasulo_pkg::ALU_SLTU: result_o[0] = a_i < b_i;
            tomasulo_pkg::ALU_XOR:  result_o = a_i ^ b_i;
            tomasulo_pkg::ALU_SRL:  result_o = a_i >> shamt;
            tomasulo_pkg::ALU_SRA:  result_o = $unsigned($signed(a_i) >>> shamt);
            tomasulo_pkg::ALU_OR:   result_o = a_i | b_i;
            tomasulo_pkg::ALU_AND:  result_o = a_i & b_i;
            default:                result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/reg_status_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_status_file (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic [tomasulo_pkg::REG_W-1:0] src1_idx_i,
    input  logic [tomasulo_pkg::REG_W-1:0] src2_idx_i,
    output tomasulo_pkg::operand_t         src1_reg_o,
    output tomasulo_pkg::operand_t         src2_reg_o,
    input  logic                           rename_i,
    input  logic [tomasulo_pkg::REG_W-1:0] rename_rd_i,
    input  logic [tomasulo_pkg::TAG_W-1:0] rename_tag_i,
    input  logic                           commit_we_i,
    input  logic [tomasulo_pkg::REG_W-1:0] commit_rd_i,
    input  logic [tomasulo_pkg::TAG_W-1:0] commit_tag_i,
    input  logic [tomasulo_pkg::XLEN-1:0]  commit_data_i
);

    logic [tomasulo_pkg::XLEN-1:0]     value_q [tomasulo_pkg::NUM_REGS];
    logic [tomasulo_pkg::TAG_W-1:0]    tag_q   [tomasulo_pkg::NUM_REGS];
    logic [tomasulo_pkg::NUM_REGS-1:0] busy_q;
    logic                              rename_ok;
    logic                              commit_ok;

    // x0 never renamed and never written
    assign rename_ok = rename_i && rename_rd_i != '0;
    assign commit_ok = commit_we_i && commit_rd_i != '0;

    function automatic tomasulo_pkg::operand_t read_reg(logic [tomasulo_pkg::REG_W-1:0] idx);
        tomasulo_pkg::operand_t res;
        res.valid = !busy_q[idx];
        res.tag   = tag_q[idx];
        res.data  = value_q[idx];
        return res;
    endfunction

    always_comb begin
        src1_reg_o = read_reg(src1_idx_i);
        src2_reg_o = read_reg(src2_idx_i);
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q <= '0;
            for (int i = 0; i < tomasulo_pkg::NUM_REGS; i++) begin
                value_q[i] <= '0;
            end
        end else begin
            if (commit_ok) begin
                value_q[commit_rd_i] <= commit_data_i;
                // only the newest producer frees the register
                if (tag_q[commit_rd_i] == commit_tag_i) begin
                    busy_q[commit_rd_i] <= 1'b0;
                end
            end
            if (rename_ok) begin
                busy_q[rename_rd_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rename_ok) begin
            tag_q[rename_rd_i] <= rename_tag_i;
        end
    end

endmodule

`default_nettype wire

//--- design/reservation_station.sv
`timescale 1ns/10ps
`default_nettype none

module reservation_station #(
    parameter int DEPTH = tomasulo_pkg::RS_DEPTH
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   load_i,
    input  tomasulo_pkg::rs_word_t word_i,
    input  tomasulo_pkg::cdb_t     cdb_i,
    output logic                   free_o,
    output tomasulo_pkg::cdb_t     req_o,
    input  logic                   grant_i
);

    // entries stay packed from slot 0, lower slots are older
    tomasulo_pkg::rs_word_t        word_q [DEPTH];
    tomasulo_pkg::rs_word_t        word_d [DEPTH];
    logic [DEPTH-1:0]              valid_q;
    logic [DEPTH-1:0]              valid_d;
    int                            sel;
    logic                          ready;
    logic [tomasulo_pkg::XLEN-1:0] alu_result;

    assign free_o = !valid_q[DEPTH-1];

    // oldest entry with both operands present
    always_comb begin
        sel   = 0;
        ready = 1'b0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (valid_q[i] && word_q[i].src1.valid && word_q[i].src2.valid) begin
                sel   = i;
                ready = 1'b1;
            end
        end
    end

    rv32i_alu alu (
        .op_i     (word_q[sel].op),
        .a_i      (word_q[sel].src1.data),
        .b_i      (word_q[sel].src2.data),
        .result_o (alu_result)
    );

    always_comb begin
        req_o.valid = ready;
        req_o.tag   = word_q[sel].dest_tag;
        req_o.data  = alu_result;
    end

    always_comb begin
        int slot;
        slot    = 0;
        valid_d = valid_q;
        for (int i = 0; i < DEPTH; i++) begin
            word_d[i]      = word_q[i];
            word_d[i].src1 = tomasulo_pkg::snoop(word_q[i].src1, cdb_i);
            word_d[i].src2 = tomasulo_pkg::snoop(word_q[i].src2, cdb_i);
        end
        // granted entry leaves, younger ones move down
        if (grant_i) begin
            for (int i = 0; i < DEPTH - 1; i++) begin
                if (i >= sel) begin
                    word_d[i]  = word_d[i + 1];
                    valid_d[i] = valid_q[i + 1];
                end
            end
            valid_d[DEPTH - 1] = 1'b0;
        end
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!valid_d[i]) begin
                slot = i;
            end
        end
        if (load_i) begin
            word_d[slot]  = word_i;
            valid_d[slot] = 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    always_ff @(posedge clk_i) begin
        word_q <= word_d;
    end

endmodule

`default_nettype wire

//--- design/cdb_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module cdb_arbiter (
    input  logic                                          clk_i,
    input  logic                                          rst_n_i,
    input  tomasulo_pkg::cdb_t [tomasulo_pkg::NUM_RS-1:0] req_i,
    output logic [tomasulo_pkg::NUM_RS-1:0]               grant_o,
    output tomasulo_pkg::cdb_t                            cdb_o
);

    logic [tomasulo_pkg::RS_SEL_W-1:0] ptr_q;
    logic [tomasulo_pkg::RS_SEL_W-1:0] win;
    logic [tomasulo_pkg::RS_SEL_W-1:0] idx;
    logic                              any;

    // search from the pointer, nearest valid request wins
    always_comb begin
        win = ptr_q;
        any = 1'b0;
        idx = ptr_q;
        for (int i = tomasulo_pkg::NUM_RS - 1; i >= 0; i--) begin
            idx = ptr_q + tomasulo_pkg::RS_SEL_W'(i);
            if (req_i[idx].valid) begin
                win = idx;
                any = 1'b1;
            end
        end
        grant_o      = '0;
        grant_o[win] = any;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ptr_q <= '0;
            cdb_o <= '0;
        end else begin
            cdb_o <= any ? req_i[win] : '0;
            // winner drops to lowest priority
            if (any) begin
                ptr_q <= win + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/reorder_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module reorder_buffer (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           alloc_i,
    input  logic [tomasulo_pkg::REG_W-1:0] alloc_rd_i,
    output logic                           full_o,
    output logic [tomasulo_pkg::TAG_W-1:0] tail_tag_o,
    input  tomasulo_pkg::cdb_t             cdb_i,
    input  logic [tomasulo_pkg::TAG_W-1:0] fwd1_tag_i,
    input  logic [tomasulo_pkg::TAG_W-1:0] fwd2_tag_i,
    output logic                           fwd1_done_o,
    output logic                           fwd2_done_o,
    output logic [tomasulo_pkg::XLEN-1:0]  fwd1_data_o,
    output logic [tomasulo_pkg::XLEN-1:0]  fwd2_data_o,
    output logic                           commit_we_o,
    output logic [tomasulo_pkg::REG_W-1:0] commit_rd_o,
    output logic [tomasulo_pkg::TAG_W-1:0] commit_tag_o,
    output logic [tomasulo_pkg::XLEN-1:0]  commit_data_o,
    output logic                           commit_valid_o,
    output tomasulo_pkg::commit_t          commit_o,
    input  logic                           commit_credit_i
);

    logic [tomasulo_pkg::REG_W-1:0]     rd_q   [tomasulo_pkg::ROB_DEPTH];
    logic [tomasulo_pkg::XLEN-1:0]      data_q [tomasulo_pkg::ROB_DEPTH];
    logic [tomasulo_pkg::ROB_DEPTH-1:0] done_q;
    logic [tomasulo_pkg::TAG_W-1:0]     head_q;
    logic [tomasulo_pkg::TAG_W-1:0]     tail_q;
    logic [tomasulo_pkg::CNT_W-1:0]     count_q;
    logic [tomasulo_pkg::CRED_W-1:0]    credit_q;

    assign full_o     = count_q == tomasulo_pkg::CNT_W'(tomasulo_pkg::ROB_DEPTH);
    assign tail_tag_o = tail_q;

    // finished results stay visible to dispatch until commit
    assign fwd1_done_o = done_q[fwd1_tag_i];
    assign fwd2_done_o = done_q[fwd2_tag_i];
    assign fwd1_data_o = data_q[fwd1_tag_i];
    assign fwd2_data_o = data_q[fwd2_tag_i];

    // head leaves only when the consumer has room
    assign commit_we_o   = count_q != '0 && done_q[head_q] && credit_q != '0;
    assign commit_rd_o   = rd_q[head_q];
    assign commit_tag_o  = head_q;
    assign commit_data_o = data_q[head_q];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            head_q         <= '0;
            tail_q         <= '0;
            count_q        <= '0;
            done_q         <= '0;
            credit_q       <= tomasulo_pkg::CRED_W'(tomasulo_pkg::COMMIT_CREDITS);
            commit_valid_o <= 1'b0;
        end else begin
            if (alloc_i) begin
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;
            end
            if (cdb_i.valid) begin
                done_q[cdb_i.tag] <= 1'b1;
            end
            if (commit_we_o) begin
                head_q <= head_q + 1'b1;
            end
            case ({alloc_i, commit_we_o})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            case ({commit_we_o, commit_credit_i})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: credit_q <= credit_q;
            endcase
            commit_valid_o <= commit_we_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            rd_q[tail_q] <= alloc_rd_i;
        end
        if (cdb_i.valid) begin
            data_q[cdb_i.tag] <= cdb_i.data;
        end
        if (commit_we_o) begin
            commit_o <= {commit_rd_o, commit_data_o};
        end
    end

endmodule

`default_nettype wire

//--- design/issue_unit.sv
`timescale 1ns/10ps
`default_nettype none

module issue_unit (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            instr_valid_i,
    input  logic [31:0]                     instr_i,
    output logic                            instr_credit_o,
    output logic [tomasulo_pkg::REG_W-1:0]  src1_idx_o,
    output logic [tomasulo_pkg::REG_W-1:0]  src2_idx_o,
    input  tomasulo_pkg::operand_t          src1_reg_i,
    input  tomasulo_pkg::operand_t          src2_reg_i,
    output logic [tomasulo_pkg::TAG_W-1:0]  fwd1_tag_o,
    output logic [tomasulo_pkg::TAG_W-1:0]  fwd2_tag_o,
    input  logic                            fwd1_done_i,
    input  logic                            fwd2_done_i,
    input  logic [tomasulo_pkg::XLEN-1:0]   fwd1_data_i,
    input  logic [tomasulo_pkg::XLEN-1:0]   fwd2_data_i,
    input  tomasulo_pkg::cdb_t              cdb_i,
    input  logic                            rob_full_i,
    input  logic [tomasulo_pkg::TAG_W-1:0]  rob_tail_tag_i,
    output logic                            rob_alloc_o,
    output logic [tomasulo_pkg::REG_W-1:0]  alloc_rd_o,
    input  logic [tomasulo_pkg::NUM_RS-1:0] rs_free_i,
    output logic [tomasulo_pkg::NUM_RS-1:0] rs_load_o,
    output tomasulo_pkg::rs_word_t          rs_word_o
);

    logic [31:0]                               queue_q [tomasulo_pkg::IQ_DEPTH];
    logic [$clog2(tomasulo_pkg::IQ_DEPTH)-1:0] head_q;
    logic [$clog2(tomasulo_pkg::IQ_DEPTH)-1:0] tail_q;
    logic [$clog2(tomasulo_pkg::IQ_DEPTH):0]   count_q;
    logic [31:0]                               word;
    logic [31:0]                               imm;
    logic                                      dispatch;
    logic                                      use_imm;
    tomasulo_pkg::alu_op_e                     op;
    tomasulo_pkg::operand_t                    src1;
    tomasulo_pkg::operand_t                    src2;

    // register file, then finished ROB entry, then the current CDB
    function automatic tomasulo_pkg::operand_t resolve(
        input tomasulo_pkg::operand_t        reg_op,
        input logic                          done,
        input logic [tomasulo_pkg::XLEN-1:0] data,
        input tomasulo_pkg::cdb_t            cdb
    );
        tomasulo_pkg::operand_t res;
        res = reg_op;
        if (!res.valid && done) begin
            res.valid = 1'b1;
            res.data  = data;
        end
        return tomasulo_pkg::snoop(res, cdb);
    endfunction

    assign word     = queue_q[head_q];
    assign dispatch = count_q != '0 && |rs_free_i && !rob_full_i;

    // anything but an ALU op issues as addi x0, x0, 0
    always_comb begin
        op         = tomasulo_pkg::ALU_ADD;
        use_imm    = 1'b1;
        imm        = '0;
        alloc_rd_o = '0;
        src1_idx_o = '0;
        src2_idx_o = '0;
        if (word[6:0] == 7'b0110011 || word[6:0] == 7'b0010011) begin
            // opcode bit 5 is clear for the immediate forms
            use_imm    = !word[5];
            imm        = {{20{word[31]}}, word[31:20]};
            alloc_rd_o = word[11:7];
            src1_idx_o = word[19:15];
            src2_idx_o = word[24:20];
            case (word[14:12])
                3'b000:  op = (!use_imm && word[30]) ? tomasulo_pkg::ALU_SUB
                                                     : tomasulo_pkg::ALU_ADD;
                3'b001:  op = tomasulo_pkg::ALU_SLL;
                3'b010:  op = tomasulo_pkg::ALU_SLT;
                3'b011:  op = tomasulo_pkg::ALU_SLTU;
                3'b100:  op = tomasulo_pkg::ALU_XOR;
                3'b101:  op = word[30] ? tomasulo_pkg::ALU_SRA : tomasulo_pkg::ALU_SRL;
                3'b110:  op = tomasulo_pkg::ALU_OR;
                default: op = tomasulo_pkg::ALU_AND;
            endcase
        end
    end

    assign fwd1_tag_o = src1_reg_i.tag;
    assign fwd2_tag_o = src2_reg_i.tag;

    always_comb begin
        src1 = resolve(src1_reg_i, fwd1_done_i, fwd1_data_i, cdb_i);
        src2 = resolve(src2_reg_i, fwd2_done_i, fwd2_data_i, cdb_i);
        if (use_imm) begin
            src2 = '{valid: 1'b1, tag: '0, data: imm};
        end
    end

    // lowest free station takes the word
    assign rob_alloc_o = dispatch;
    assign rs_load_o   = dispatch ? (rs_free_i & (~rs_free_i + 1'b1)) : '0;
    assign rs_word_o   = '{op: op, src1: src1, src2: src2, dest_tag: rob_tail_tag_i};

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            head_q         <= '0;
            tail_q         <= '0;
            count_q        <= '0;
            instr_credit_o <= 1'b0;
        end else begin
            if (instr_valid_i) begin
                tail_q <= tail_q + 1'b1;
            end
            if (dispatch) begin
                head_q <= head_q + 1'b1;
            end
            case ({instr_valid_i, dispatch})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            // freed slot goes back to the producer
            instr_credit_o <= dispatch;
        end
    end

    always_ff @(posedge clk_i) begin
        if (instr_valid_i) begin
            queue_q[tail_q] <= instr_i;
        end
    end

endmodule

`default_nettype wire

//--- design/tomasulo_core.sv
`timescale 1ns/10ps
`default_nettype none

module tomasulo_core (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  instr_valid_i,
    input  logic [31:0]           instr_i,
    output logic                  instr_credit_o,
    output logic                  commit_valid_o,
    output tomasulo_pkg::commit_t commit_o,
    input  logic                  commit_credit_i
);

    logic [tomasulo_pkg::REG_W-1:0]                src1_idx, src2_idx;
    tomasulo_pkg::operand_t                        src1_reg, src2_reg;
    logic [tomasulo_pkg::TAG_W-1:0]                fwd1_tag, fwd2_tag;
    logic                                          fwd1_done, fwd2_done;
    logic [tomasulo_pkg::XLEN-1:0]                 fwd1_data, fwd2_data;
    tomasulo_pkg::cdb_t                            cdb;
    logic                                          rob_full;
    logic [tomasulo_pkg::TAG_W-1:0]                rob_tail_tag;
    logic                                          rob_alloc;
    logic [tomasulo_pkg::REG_W-1:0]                alloc_rd;
    logic [tomasulo_pkg::NUM_RS-1:0]               rs_free, rs_load, rs_grant;
    tomasulo_pkg::rs_word_t                        rs_word;
    tomasulo_pkg::cdb_t [tomasulo_pkg::NUM_RS-1:0] rs_req;
    logic                                          commit_we;
    logic [tomasulo_pkg::REG_W-1:0]                commit_rd;
    logic [tomasulo_pkg::TAG_W-1:0]                commit_tag;
    logic [tomasulo_pkg::XLEN-1:0]                 commit_data;

    issue_unit iq (
        .clk_i, .rst_n_i, .instr_valid_i, .instr_i, .instr_credit_o,
        .src1_idx_o (src1_idx), .src2_idx_o (src2_idx),
        .src1_reg_i (src1_reg), .src2_reg_i (src2_reg),
        .fwd1_tag_o (fwd1_tag), .fwd2_tag_o (fwd2_tag),
        .fwd1_done_i (fwd1_done), .fwd2_done_i (fwd2_done),
        .fwd1_data_i (fwd1_data), .fwd2_data_i (fwd2_data),
        .cdb_i (cdb), .rob_full_i (rob_full), .rob_tail_tag_i (rob_tail_tag),
        .rob_alloc_o (rob_alloc), .alloc_rd_o (alloc_rd),
        .rs_free_i (rs_free), .rs_load_o (rs_load), .rs_word_o (rs_word)
    );

    // rename uses the tag the ROB hands out this cycle
    reg_status_file regfile (
        .clk_i, .rst_n_i,
        .src1_idx_i (src1_idx), .src2_idx_i (src2_idx),
        .src1_reg_o (src1_reg), .src2_reg_o (src2_reg),
        .rename_i (rob_alloc), .rename_rd_i (alloc_rd), .rename_tag_i (rob_tail_tag),
        .commit_we_i (commit_we), .commit_rd_i (commit_rd),
        .commit_tag_i (commit_tag), .commit_data_i (commit_data)
    );

    for (genvar g = 0; g < tomasulo_pkg::NUM_RS; g++) begin : gen_res
        reservation_station #(
            .DEPTH (tomasulo_pkg::RS_DEPTH)
        ) res (
            .clk_i, .rst_n_i,
            .load_i (rs_load[g]), .word_i (rs_word), .cdb_i (cdb),
            .free_o (rs_free[g]), .req_o (rs_req[g]), .grant_i (rs_grant[g])
        );
    end

    cdb_arbiter arb (
        .clk_i, .rst_n_i, .req_i (rs_req), .grant_o (rs_grant), .cdb_o (cdb)
    );

    reorder_buffer rob (
        .clk_i, .rst_n_i,
        .alloc_i (rob_alloc), .alloc_rd_i (alloc_rd),
        .full_o (rob_full), .tail_tag_o (rob_tail_tag), .cdb_i (cdb),
        .fwd1_tag_i (fwd1_tag), .fwd2_tag_i (fwd2_tag),
        .fwd1_done_o (fwd1_done), .fwd2_done_o (fwd2_done),
        .fwd1_data_o (fwd1_data), .fwd2_data_o (fwd2_data),
        .commit_we_o (commit_we), .commit_rd_o (commit_rd),
        .commit_tag_o (commit_tag), .commit_data_o (commit_data),
        .commit_valid_o, .commit_o, .commit_credit_i
    );

endmodule

`default_nettype wire

//--- sim/tomasulo_tb.sv
`timescale 1ns/10ps
`default_nettype none

module tomasulo_tb;

    localparam int NUM_INSTR    = 400;
    localparam int CHAIN_START  = 150;
    localparam int BURST_AT     = 280;
    localparam int BURST_CYCLES = 30;
    localparam int LIMIT_CYCLES = NUM_INSTR * 40 + 200;

    logic                  clk;
    logic                  rst_n;
    logic                  instr_valid;
    logic [31:0]           instr;
    logic                  instr_credit;
    logic                  commit_valid;
    tomasulo_pkg::commit_t commit;
    logic                  commit_credit;

    logic [15:0]           lfsr;
    logic [31:0]           regs [32];
    tomasulo_pkg::commit_t expected [$];
    int                    expected_idx [$];
    int                    sent;
    int                    commits;
    int                    in_credits;
    int                    out_credits;
    int                    burst_state;
    int                    burst_left;
    int                    burst_budget;
    int                    burst_commits;
    int                    mismatches;
    int                    errors;
    logic                  started;

    tomasulo_core dut_i (
        .clk_i           (clk),
        .rst_n_i         (rst_n),
        .instr_valid_i   (instr_valid),
        .instr_i         (instr),
        .instr_credit_o  (instr_credit),
        .commit_valid_o  (commit_valid),
        .commit_o        (commit),
        .commit_credit_i (commit_credit)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // galois step for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // RV32I result by funct3 and the alt bit for sub or sra
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> sh) : a >> sh;
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic string phase_name(input int idx);
        if (idx < CHAIN_START) begin
            return "random_mix";
        end else if (idx < BURST_AT) begin
            return "reg_chain";
        end
        return "credit_burst";
    endfunction

    task automatic send_instr();
        logic [31:0]           r;
        logic [31:0]           a;
        logic [31:0]           b;
        logic [31:0]           res;
        logic [11:0]           imm;
        logic [6:0]            funct7;
        logic [4:0]            rd;
        logic [4:0]            rs1;
        logic [4:0]            rs2;
        logic [2:0]            f3;
        logic                  is_imm;
        logic                  alt;
        int                    reg_bits;
        tomasulo_pkg::commit_t rec;
        // middle of the stream only touches x0 to x3
        reg_bits = (sent >= CHAIN_START && sent < BURST_AT) ? 2 : 3;
        draw(4, r);
        if (r[3:0] == 4'hf) begin
            // load opcode retires as addi x0, x0, 0
            draw(25, r);
            instr = {r[24:0], 7'b0000011};
            rec   = '0;
        end else begin
            draw(3, r);
            f3 = r[2:0];
            draw(reg_bits, r);
            rd = r[4:0];
            draw(reg_bits, r);
            rs1 = r[4:0];
            draw(reg_bits, r);
            rs2 = r[4:0];
            draw(12, r);
            imm = r[11:0];
            draw(1, r);
            is_imm = r[0];
            draw(1, r);
            // funct7 bit 5 only for sub, sra and srai
            alt    = r[0] && (f3 == 3'd5 || (f3 == 3'd0 && !is_imm));
            funct7 = alt ? 7'h20 : 7'h00;
            if (is_imm && (f3 == 3'd1 || f3 == 3'd5)) begin
                imm = {funct7, imm[4:0]};
            end
            a   = regs[rs1];
            b   = is_imm ? {{20{imm[11]}}, imm} : regs[rs2];
            res = alu_ref(f3, alt, a, b);
            if (is_imm) begin
                instr = {imm, rs1, f3, rd, 7'b0010011};
            end else begin
                instr = {funct7, rs2, rs1, f3, rd, 7'b0110011};
            end
            // x0 keeps reading zero while the record still carries the result
            if (rd != 5'd0) begin
                regs[rd] = res;
            end
            rec.rd   = rd;
            rec.data = res;
        end
        instr_valid = 1'b1;
        started     = 1'b1;
        in_credits--;
        expected.push_back(rec);
        expected_idx.push_back(sent);
        sent++;
    endtask

    task automatic check_commit();
        tomasulo_pkg::commit_t exp;
        int                    idx;
        assert (expected.size() != 0) else begin
            $display("commit record arrived with no instruction outstanding");
            errors++;
        end
        if (expected.size() != 0) begin
            exp = expected.pop_front();
            idx = expected_idx.pop_front();
            assert (commit == exp) else begin
                $display("MISMATCH %s #%0d expected rd=%0d data=%08h actual rd=%0d data=%08h",
                         phase_name(idx), idx, exp.rd, exp.data, commit.rd, commit.data);
                mismatches++;
            end
        end
    endtask

    task automatic sample_outputs();
        if (!started) begin
            assert (!commit_valid && !instr_credit) else begin
                $display("core output active before the first instruction was sent");
                errors++;
            end
        end
        if (instr_credit) begin
            in_credits++;
            assert (in_credits <= tomasulo_pkg::IQ_DEPTH) else begin
                $display("more input credits returned than were spent, %0d held", in_credits);
                errors++;
            end
        end
        if (commit_valid) begin
            assert (out_credits > 0) else begin
                $display("commit sent while the core held no output credit");
                errors++;
            end
            out_credits--;
            commits++;
            if (burst_state == 1) begin
                burst_commits++;
            end
            check_commit();
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        instr_valid   = 1'b0;
        commit_credit = 1'b0;
        if (sent < NUM_INSTR && in_credits > 0) begin
            draw(2, r);
            if (r[1:0] != 2'b00) begin
                send_instr();
            end
        end
        // consumer holds back all credits once
        if (burst_state == 0 && sent >= BURST_AT) begin
            burst_state   = 1;
            burst_left    = BURST_CYCLES;
            burst_budget  = out_credits;
            burst_commits = 0;
        end else if (burst_state == 1) begin
            burst_left--;
            if (burst_left == 0) begin
                assert (burst_commits <= burst_budget) else begin
                    $display("%0d commits during the credit stall with only %0d credits held",
                             burst_commits, burst_budget);
                    errors++;
                end
                burst_state = 2;
            end
        end
        if (burst_state != 1 && out_credits < tomasulo_pkg::COMMIT_CREDITS) begin
            draw(2, r);
            if (r[1:0] != 2'b00) begin
                commit_credit = 1'b1;
                out_credits++;
            end
        end
    endtask

    initial begin : main
        int   cycle;
        logic finished;
        rst_n         = 1'b0;
        instr_valid   = 1'b0;
        instr         = '0;
        commit_credit = 1'b0;
        lfsr          = 16'd26774;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        sent        = 0;
        commits     = 0;
        in_credits  = tomasulo_pkg::IQ_DEPTH;
        out_credits = tomasulo_pkg::COMMIT_CREDITS;
        burst_state = 0;
        burst_left  = 0;
        mismatches  = 0;
        errors      = 0;
        started     = 1'b0;
        cycle       = 0;
        finished    = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        while (!finished) begin
            @(negedge clk);
            sample_outputs();
            @(posedge clk);
            #1;
            // outputs must stay quiet over a few idle cycles
            if (cycle >= 5) begin
                drive_inputs();
            end
            cycle++;
            finished = sent == NUM_INSTR && expected.size() == 0 && burst_state == 2;
        end
        repeat (4) begin
            @(posedge clk);
            #1;
            instr_valid   = 1'b0;
            commit_credit = 1'b0;
            @(negedge clk);
            sample_outputs();
        end
        assert (in_credits == tomasulo_pkg::IQ_DEPTH) else begin
            $display("only %0d of %0d input credits returned after the stream drained",
                     in_credits, tomasulo_pkg::IQ_DEPTH);
            errors++;
        end
        assert (commits == NUM_INSTR) else begin
            $display("MISMATCH commit_count expected %0d actual %0d", NUM_INSTR, commits);
            mismatches++;
        end
        $display("%0d sent, %0d committed, %0d mismatches, %0d other errors",
                 sent, commits, mismatches, errors);
        if (mismatches == 0 && errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("run did not finish within %0d cycles, %0d of %0d instructions committed",
                 LIMIT_CYCLES, commits, NUM_INSTR);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
design/tomasulo_pkg.sv
design/rv32i_alu.sv
design/reg_status_file.sv
design/reservation_station.sv
design/cdb_arbiter.sv
design/reorder_buffer.sv
design/issue_unit.sv
design/tomasulo_core.sv
sim/tomasulo_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the Tomasulo core testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f compile.f \
        --top-module tomasulo_tb -o tomasulo_sim; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tomasulo_sim)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Everything OK"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
